// ==== common/fetch_macros.svh ====
// ************************************************************
// Fetch subsystem sizes shared by the package and the RTL.
// ************************************************************
`ifndef FETCH_MACROS_SVH
`define FETCH_MACROS_SVH

// byte address space of the CPU.
`define FETCH_ADDR_W 24

// RAM data port width.
`define FETCH_BUS_W 16

// request FIFO depth, also the requester's starting credits.
`define FETCH_REQ_DEPTH 4

// response FIFO depth.
`define FETCH_RESP_DEPTH 4

// consumer buffer size, the sender's starting credits.
`define FETCH_RESP_CREDITS 2

`endif

// ==== common/fetch_pkg.sv ====
// ************************************************************
// Fetch package with the shared vector types and window states.
// ************************************************************
`default_nettype none

`include "fetch_macros.svh"

package fetch_pkg;

    // byte address.
    typedef logic [`FETCH_ADDR_W-1:0] byte_addr_t;

    // one RAM halfword.
    typedef logic [`FETCH_BUS_W-1:0] bus_word_t;

    // four bytes, little-endian.
    // byte k of the address sits in bits 8k+7 down to 8k.
    typedef logic [2*`FETCH_BUS_W-1:0] fetch_data_t;

    // one bit per window byte.
    typedef logic [3:0] byte_mask_t;

    // window sequencer.
    typedef enum logic [1:0] {
        WIN_IDLE,
        WIN_FILL,
        WIN_DONE
    } win_state_t;

endpackage

`default_nettype wire

// ==== fetch/fetch_window.sv ====
// ************************************************************
// Fetch window. Keeps four bytes from the 16-bit RAM port
// and reloads only those missing for each new address.
// ************************************************************
`timescale 1ns/1ps
`default_nettype none

`include "fetch_macros.svh"

module fetch_window (
    input  wire                         clk,
    input  wire                         rst,
    input  wire                         cen,
    input  wire                         q_valid,
    input  wire fetch_pkg::byte_addr_t  q_addr,
    output logic                        q_pop,
    input  wire                         resp_space,
    output fetch_pkg::byte_addr_t       ram_addr,
    input  wire fetch_pkg::bus_word_t   ram_dout,
    output logic                        done,
    output fetch_pkg::byte_addr_t       done_addr,
    output fetch_pkg::fetch_data_t      done_data
);

    fetch_pkg::win_state_t  state;
    fetch_pkg::byte_addr_t  cache_addr;
    fetch_pkg::fetch_data_t win_data;
    fetch_pkg::byte_mask_t  valid;
    fetch_pkg::byte_mask_t  pend;

    // new request decode.
    fetch_pkg::byte_addr_t  offset;
    logic [2:0]             shift;
    fetch_pkg::byte_mask_t  keep;

    // fill step decode.
    logic [1:0]             lo_idx;
    logic [1:0]             hi_idx;
    logic                   pair;
    logic [7:0]             lo_byte;
    fetch_pkg::byte_mask_t  fill_mask;
    fetch_pkg::byte_mask_t  pend_nx;

    // take the head only when idle and a response slot is free.
    assign q_pop = (state == fetch_pkg::WIN_IDLE) && cen && q_valid && resp_space;

    // shift of 0..3 reuses bytes, 4 means a full refill.
    always_comb begin
        offset = q_addr - cache_addr;
        shift  = 3'd4;
        if (offset < fetch_pkg::byte_addr_t'(4)) begin
            // bytes from offset upwards must all be held.
            if (((valid >> offset[1:0]) | ~(4'hf >> offset[1:0])) == 4'hf) begin
                shift = {1'b0, offset[1:0]};
            end
        end
        keep = fetch_pkg::byte_mask_t'(4'hf >> shift);
    end

    // lowest pending byte lines up with ram_addr.
    always_comb begin
        lo_idx = 2'd3;
        for (int i = 3; i >= 0; i--) begin
            if (pend[i]) begin
                lo_idx = 2'(i);
            end
        end
        hi_idx = lo_idx + 2'd1;
        // an even address gives two bytes in one read.
        pair      = !ram_addr[0] && (lo_idx != 2'd3) && pend[hi_idx];
        lo_byte   = ram_addr[0] ? ram_dout[15:8] : ram_dout[7:0];
        fill_mask = fetch_pkg::byte_mask_t'(4'b0001 << lo_idx);
        if (pair) begin
            fill_mask = fill_mask | fetch_pkg::byte_mask_t'(4'b0001 << hi_idx);
        end
        pend_nx = pend & ~fill_mask;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state      <= fetch_pkg::WIN_IDLE;
            cache_addr <= '0;
            valid      <= '0;
            pend       <= '0;
            ram_addr   <= '0;
        end else if (cen) begin
            case (state)
                fetch_pkg::WIN_IDLE: begin
                    if (q_pop) begin
                        cache_addr <= q_addr;
                        valid      <= keep;
                        pend       <= ~keep;
                        // first missing byte follows the kept ones.
                        ram_addr   <= q_addr + fetch_pkg::byte_addr_t'(3'd4 - shift);
                        if (keep == 4'hf) begin
                            state <= fetch_pkg::WIN_DONE;
                        end else begin
                            state <= fetch_pkg::WIN_FILL;
                        end
                    end
                end
                fetch_pkg::WIN_FILL: begin
                    // zero wait states, one read per enabled cycle.
                    ram_addr <= ram_addr + (pair ? fetch_pkg::byte_addr_t'(2)
                                                 : fetch_pkg::byte_addr_t'(1));
                    valid    <= valid | fill_mask;
                    pend     <= pend_nx;
                    if (pend_nx == '0) begin
                        state <= fetch_pkg::WIN_DONE;
                    end
                end
                fetch_pkg::WIN_DONE: begin
                    state <= fetch_pkg::WIN_IDLE;
                end
                default: begin
                    state <= fetch_pkg::WIN_IDLE;
                end
            endcase
        end
    end

    // window bytes.
    always_ff @(posedge clk) begin
        if (cen) begin
            if (q_pop) begin
                // surviving bytes move down.
                win_data <= win_data >> {shift, 3'b000};
            end else if (state == fetch_pkg::WIN_FILL) begin
                win_data[{lo_idx, 3'b000} +: 8] <= lo_byte;
                if (pair) begin
                    win_data[{hi_idx, 3'b000} +: 8] <= ram_dout[15:8];
                end
            end
        end
    end

    // one cycle per finished fetch.
    assign done      = (state == fetch_pkg::WIN_DONE) && cen;
    assign done_addr = cache_addr;
    assign done_data = win_data;

    // a finished fetch carries four loaded bytes.
    a_done_full: assert property (@(posedge clk) disable iff (rst)
        done |-> (valid == 4'hf) && (pend == '0));

    // each fill read addresses the lowest missing byte.
    a_fill_align: assert property (@(posedge clk) disable iff (rst)
        (state == fetch_pkg::WIN_FILL) |->
            (ram_addr == cache_addr + fetch_pkg::byte_addr_t'(lo_idx)));

endmodule

`default_nettype wire

// ==== flist.f ====
+incdir+common
common/fetch_pkg.sv
hdl/fetch_req_queue.sv
hdl/fetch_resp_queue.sv
fetch/fetch_window.sv
hdl/fetch_top.sv
sim/fetch_ram_model.sv
sim/fetch_tb.sv

// ==== hdl/fetch_req_queue.sv ====
// ************************************************************
// Request queue. Holds byte addresses and returns credits.
// ************************************************************
`timescale 1ns/1ps
`default_nettype none

`include "fetch_macros.svh"

module fetch_req_queue (
    input  wire                         clk,
    input  wire                         rst,
    input  wire                         req_valid,
    input  wire fetch_pkg::byte_addr_t  req_addr,
    input  wire                         q_pop,
    output logic                        q_valid,
    output fetch_pkg::byte_addr_t       q_addr,
    output logic                        req_credit
);

    localparam int DEPTH = `FETCH_REQ_DEPTH;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    fetch_pkg::byte_addr_t mem [DEPTH];
    logic [PTR_W-1:0]      wr_ptr;
    logic [PTR_W-1:0]      rd_ptr;
    logic [CNT_W-1:0]      count;
    logic                  pop;

    assign q_valid = (count != '0);
    assign q_addr  = mem[rd_ptr];
    assign pop     = q_pop && q_valid;

    // address storage.
    always_ff @(posedge clk) begin
        if (req_valid) begin
            mem[wr_ptr] <= req_addr;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            req_credit <= 1'b0;
        end else begin
            if (req_valid) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({req_valid, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            // each freed slot goes back to the requester.
            req_credit <= pop;
        end
    end

    // the requester only pushes while holding a credit.
    a_no_overflow: assert property (@(posedge clk) disable iff (rst)
        req_valid |-> (count != CNT_W'(DEPTH)));

endmodule

`default_nettype wire

// ==== hdl/fetch_resp_queue.sv ====
// ************************************************************
// Response queue. Sends finished fetches against credits.
// ************************************************************
`timescale 1ns/1ps
`default_nettype none

`include "fetch_macros.svh"

module fetch_resp_queue (
    input  wire                         clk,
    input  wire                         rst,
    input  wire                         done,
    input  wire fetch_pkg::byte_addr_t  done_addr,
    input  wire fetch_pkg::fetch_data_t done_data,
    output logic                        resp_space,
    output logic                        resp_valid,
    output fetch_pkg::byte_addr_t       resp_addr,
    output fetch_pkg::fetch_data_t      resp_data,
    input  wire                         resp_credit
);

    localparam int DEPTH  = `FETCH_RESP_DEPTH;
    localparam int PTR_W  = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W  = $clog2(DEPTH + 1);
    localparam int CRED   = `FETCH_RESP_CREDITS;
    localparam int CRED_W = $clog2(CRED + 2);

    fetch_pkg::byte_addr_t  addr_mem [DEPTH];
    fetch_pkg::fetch_data_t data_mem [DEPTH];
    logic [PTR_W-1:0]       wr_ptr;
    logic [PTR_W-1:0]       rd_ptr;
    logic [CNT_W-1:0]       count;
    logic [CRED_W-1:0]      credits;

    // the window has at most one fetch in flight and pops only when idle.
    // so a free slot here already covers its reservation.
    assign resp_space = (count < CNT_W'(DEPTH));

    // send the head whenever the consumer has room.
    assign resp_valid = (count != '0) && (credits != '0);
    assign resp_addr  = addr_mem[rd_ptr];
    assign resp_data  = data_mem[rd_ptr];

    // payload storage.
    always_ff @(posedge clk) begin
        if (done) begin
            addr_mem[wr_ptr] <= done_addr;
            data_mem[wr_ptr] <= done_data;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            count   <= '0;
            credits <= CRED_W'(CRED);
        end else begin
            if (done) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (resp_valid) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({done, resp_valid})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            // one credit spent per send, one back per consumer pulse.
            case ({resp_valid, resp_credit})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;
            endcase
        end
    end

    // the consumer returns no more than it was given.
    a_credit_max: assert property (@(posedge clk) disable iff (rst)
        resp_credit |=> (credits <= CRED_W'(CRED)));

    // the window reserved a slot before starting this fetch.
    a_no_overflow: assert property (@(posedge clk) disable iff (rst)
        done |-> (count != CNT_W'(DEPTH)));

endmodule

`default_nettype wire

// ==== hdl/fetch_top.sv ====
// ************************************************************
// Fetch top. Request queue, window and response queue.
// ************************************************************
`timescale 1ns/1ps
`default_nettype none

`include "fetch_macros.svh"

module fetch_top (
    input  wire                         clk,
    input  wire                         rst,
    input  wire                         cen,
    input  wire                         req_valid,
    input  wire fetch_pkg::byte_addr_t  req_addr,
    output wire                         req_credit,
    output wire fetch_pkg::byte_addr_t  ram_addr,
    input  wire fetch_pkg::bus_word_t   ram_dout,
    output wire                         resp_valid,
    output wire fetch_pkg::byte_addr_t  resp_addr,
    output wire fetch_pkg::fetch_data_t resp_data,
    input  wire                         resp_credit
);

    // queue head to window.
    logic                   q_valid;
    fetch_pkg::byte_addr_t  q_addr;
    logic                   q_pop;

    // window to response queue.
    logic                   resp_space;
    logic                   done;
    fetch_pkg::byte_addr_t  done_addr;
    fetch_pkg::fetch_data_t done_data;

    fetch_req_queue u_req_queue (
        .clk        (clk),
        .rst        (rst),
        .req_valid  (req_valid),
        .req_addr   (req_addr),
        .q_pop      (q_pop),
        .q_valid    (q_valid),
        .q_addr     (q_addr),
        .req_credit (req_credit)
    );

    fetch_window u_window (
        .clk        (clk),
        .rst        (rst),
        .cen        (cen),
        .q_valid    (q_valid),
        .q_addr     (q_addr),
        .q_pop      (q_pop),
        .resp_space (resp_space),
        .ram_addr   (ram_addr),
        .ram_dout   (ram_dout),
        .done       (done),
        .done_addr  (done_addr),
        .done_data  (done_data)
    );

    fetch_resp_queue u_resp_queue (
        .clk         (clk),
        .rst         (rst),
        .done        (done),
        .done_addr   (done_addr),
        .done_data   (done_data),
        .resp_space  (resp_space),
        .resp_valid  (resp_valid),
        .resp_addr   (resp_addr),
        .resp_data   (resp_data),
        .resp_credit (resp_credit)
    );

endmodule

`default_nettype wire

// ==== sim/fetch_ram_model.sv ====
// ************************************************************
// RAM model for the fetch port. 16-bit combinational read,
// byte b holds the low bits of b*7+3.
// ************************************************************
`timescale 1ns/1ps
`default_nettype none

`include "fetch_macros.svh"

module fetch_ram_model (
    input  wire fetch_pkg::byte_addr_t addr,
    output fetch_pkg::bus_word_t       dout
);

    fetch_pkg::byte_addr_t even_addr;

    // contents of one byte location.
    function automatic logic [7:0] pattern_byte(input fetch_pkg::byte_addr_t b);
        logic [31:0] prod;
        prod = 32'(b) * 32'd7 + 32'd3;
        return prod[7:0];
    endfunction

    // halfword n holds byte 2n low and byte 2n+1 high.
    always_comb begin
        even_addr = {addr[`FETCH_ADDR_W-1:1], 1'b0};
        dout      = {pattern_byte(even_addr + 1'b1), pattern_byte(even_addr)};
    end

endmodule

`default_nettype wire

// ==== sim/fetch_tb.sv ====
// ************************************************************
// Fetch subsystem testbench. Table of addresses with expected
// data, random clock enable and consumer credit gaps.
// ************************************************************
`timescale 1ns/1ps
`default_nettype none

`include "fetch_macros.svh"

module fetch_tb;

    localparam int CLK_PERIOD     = 20;
    localparam int NUM_ROWS       = 16;
    localparam int TIMEOUT_CYCLES = NUM_ROWS * 40 + 20;
    // consumer holds its credits back inside this cycle range.
    localparam int HOLD_START     = 40;
    localparam int HOLD_END       = 120;

    logic                   clk;
    logic                   rst;
    logic                   cen;
    logic                   req_valid;
    fetch_pkg::byte_addr_t  req_addr;
    wire                    req_credit;
    fetch_pkg::byte_addr_t  ram_addr;
    fetch_pkg::bus_word_t   ram_dout;
    wire                    resp_valid;
    fetch_pkg::byte_addr_t  resp_addr;
    fetch_pkg::fetch_data_t resp_data;
    logic                   resp_credit;

    // request table and its expected responses.
    fetch_pkg::byte_addr_t  row_addr [NUM_ROWS];
    fetch_pkg::fetch_data_t row_data [NUM_ROWS];

    logic [15:0] lfsr;
    int          errors;
    int          checks;
    int          req_credits;
    int          credit_pulses;
    int          resp_count;
    int          held;
    int          cycle;
    logic        active;

    fetch_top dut_i (
        .clk         (clk),
        .rst         (rst),
        .cen         (cen),
        .req_valid   (req_valid),
        .req_addr    (req_addr),
        .req_credit  (req_credit),
        .ram_addr    (ram_addr),
        .ram_dout    (ram_dout),
        .resp_valid  (resp_valid),
        .resp_addr   (resp_addr),
        .resp_data   (resp_data),
        .resp_credit (resp_credit)
    );

    fetch_ram_model ram_i (
        .addr (ram_addr),
        .dout (ram_dout)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // galois lfsr, one step per bit.
    function automatic logic take_bit();
        lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hb400) : (lfsr >> 1);
        return lfsr[0];
    endfunction

    function automatic fetch_pkg::byte_addr_t take_addr();
        fetch_pkg::byte_addr_t a;
        for (int i = 0; i < `FETCH_ADDR_W; i++) begin
            a[i] = take_bit();
        end
        return a;
    endfunction

    // ram rule for one byte.
    function automatic logic [7:0] ram_byte(input fetch_pkg::byte_addr_t b);
        logic [31:0] v;
        v = 32'(b) * 32'd7 + 32'd3;
        return v[7:0];
    endfunction

    // four bytes from a, little-endian.
    function automatic fetch_pkg::fetch_data_t expected_data(input fetch_pkg::byte_addr_t a);
        fetch_pkg::fetch_data_t d;
        for (int k = 0; k < 4; k++) begin
            d[8*k +: 8] = ram_byte(a + fetch_pkg::byte_addr_t'(k));
        end
        return d;
    endfunction

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("ERROR at %0t ns: %s is %h, expected %h", $time, what, actual, expected);
        end
    endtask

    task automatic build_table();
        // mix of full refills, shifts of 1..3 and repeats.
        row_addr[0]  = 24'h000010;
        row_addr[1]  = 24'h000011;
        row_addr[2]  = 24'h000013;
        row_addr[3]  = 24'h000016;
        row_addr[4]  = 24'h000016;
        row_addr[5]  = 24'h000203;
        row_addr[6]  = 24'h000204;
        row_addr[7]  = 24'h000204;
        row_addr[8]  = 24'h000207;
        // far random jump, then a shift from there.
        row_addr[9]  = take_addr();
        row_addr[10] = row_addr[9] + 24'd2;
        row_addr[11] = 24'h7c3a51;
        row_addr[12] = 24'h7c3a53;
        row_addr[13] = 24'h000000;
        row_addr[14] = 24'h000001;
        row_addr[15] = 24'h000005;
        for (int i = 0; i < NUM_ROWS; i++) begin
            row_data[i] = expected_data(row_addr[i]);
        end
    endtask

    // output sampling at the rising edge.
    always @(posedge clk) begin
        active <= !rst;
        if (!rst) begin
            cycle <= cycle + 1;
            if (req_credit) begin
                req_credits++;
                credit_pulses++;
            end
            if (resp_valid) begin
                check_value(32'(held < `FETCH_RESP_CREDITS), 32'd1, "credit held at response");
                if (resp_count < NUM_ROWS) begin
                    check_value(32'(resp_addr), 32'(row_addr[resp_count]), "resp_addr");
                    check_value(resp_data, row_data[resp_count], "resp_data");
                end else begin
                    check_value(resp_count + 1, NUM_ROWS, "response count");
                end
                resp_count++;
                held++;
            end
        end
    end

    // clock enable and consumer credits, one process for one lfsr order.
    always @(negedge clk) begin
        if (!active) begin
            cen         = 1'b0;
            resp_credit = 1'b0;
        end else begin
            // enabled about three cycles in four.
            cen         = take_bit();
            cen         = take_bit() | cen;
            resp_credit = 1'b0;
            if (held > 0 && !(cycle >= HOLD_START && cycle < HOLD_END)) begin
                if (take_bit()) begin
                    resp_credit = 1'b1;
                    held--;
                end
            end
        end
    end

    initial begin
        #(TIMEOUT_CYCLES * CLK_PERIOD);
        $display("timeout: only %0d of %0d responses arrived", resp_count, NUM_ROWS);
        $display("TB FAILED");
        $finish;
    end

    initial begin
        int i;
        rst           = 1'b1;
        cen           = 1'b0;
        req_valid     = 1'b0;
        req_addr      = '0;
        resp_credit   = 1'b0;
        lfsr          = 16'd66;
        errors        = 0;
        checks        = 0;
        req_credits   = `FETCH_REQ_DEPTH;
        credit_pulses = 0;
        resp_count    = 0;
        held          = 0;
        cycle         = 0;
        active        = 1'b0;
        build_table();

        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // quiet ports before the first request.
        repeat (3) begin
            @(posedge clk);
            check_value(32'(req_credit), 32'd0, "req_credit after reset");
            check_value(32'(resp_valid), 32'd0, "resp_valid after reset");
            check_value(32'(ram_addr), 32'd0, "ram_addr after reset");
        end

        // requester sends while it holds credits.
        i = 0;
        while (i < NUM_ROWS) begin
            @(negedge clk);
            if (req_credits > 0) begin
                req_valid = 1'b1;
                req_addr  = row_addr[i];
                req_credits--;
                i++;
            end else begin
                req_valid = 1'b0;
            end
        end
        @(negedge clk);
        req_valid = 1'b0;

        wait (resp_count >= NUM_ROWS && credit_pulses >= NUM_ROWS);
        // extra time to catch duplicate responses.
        repeat (20) @(posedge clk);
        check_value(resp_count, NUM_ROWS, "total responses");
        check_value(credit_pulses, NUM_ROWS, "req_credit pulses");
        check_value(req_credits, `FETCH_REQ_DEPTH, "requester credits at end");

        $display("checks %0d, errors %0d, responses %0d", checks, errors, resp_count);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
